//--- src/l2_defines.svh
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// address split: tag | index | word | byte
`define L2_ADDR_W      32
`define L2_DATA_W      32
`define L2_BYTE_OFF_W  2
`define L2_WORD_SEL_W  2
`define L2_WORDS       4
`define L2_BLOCK_W     128
`define L2_INDEX_W     4
`define L2_SETS        16
`define L2_TAG_W       24

`define L2_WAYS        8
`define L2_WAY_W       3
`define L2_PLRU_W      7    // ways - 1 tree nodes

`endif

//--- src/l2_pkg.sv
`include "l2_defines.svh"

package l2_pkg;

    typedef enum logic {
        L1_ICACHE = 1'b0,
        L1_DCACHE = 1'b1
    } l1_src_t;

    // request held while the FSM works on it
    typedef struct packed {
        l1_src_t               src;
        logic                  wr;     // dcache word write
        logic [`L2_ADDR_W-1:0] addr;
        logic [`L2_DATA_W-1:0] wdata;
    } l1_req_t;

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////

    typedef struct packed {
        logic                   req_r;
        logic                   req_w;
        logic                   rdy;    // ready for read data
        logic [`L2_ADDR_W-1:0]  addr;
        logic [`L2_BLOCK_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   addr_ok_r;
        logic                   addr_ok_w;
        logic                   data_ok;
        logic [`L2_BLOCK_W-1:0] rdata;
    } mem_resp_t;

    typedef logic [`L2_WAYS-1:0] way_vec_t;

    // strobes from the FSM
    typedef struct packed {
        logic                 fill;        // whole block into way
        logic                 word_we;
        logic                 use_way;     // plru touch
        logic [`L2_WAY_W-1:0] way;
        logic                 set_dirty;
        logic                 clr_dirty;
        logic                 capture_wb;
        logic                 req_r;
        logic                 req_w;
        logic                 rdy;
        logic                 return_fill; // rdata from memory block
    } fsm_ctrl_t;

endpackage

//--- src/l2_req_buffer.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_req_buffer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  icache_req,
    input  logic [`L2_ADDR_W-1:0] icache_addr,
    input  logic                  dcache_req,
    input  logic                  dcache_wr,
    input  logic [`L2_ADDR_W-1:0] dcache_addr,
    input  logic [`L2_DATA_W-1:0] dcache_wdata,
    input  logic                  idle,
    output logic                  icache_addr_ok,
    output logic                  dcache_addr_ok,
    output logic                  accept,
    output l2_pkg::l1_req_t       req
);
    import l2_pkg::*;

    // dcache wins a tie, icache waits with its level held
    assign dcache_addr_ok = idle & dcache_req;
    assign icache_addr_ok = idle & icache_req & ~dcache_req;
    assign accept         = dcache_addr_ok | icache_addr_ok;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req <= '0;
        end else if (accept) begin
            if (dcache_req) begin
                req.src   <= L1_DCACHE;
                req.wr    <= dcache_wr;
                req.addr  <= dcache_addr;
                req.wdata <= dcache_wdata;
            end else begin
                req.src   <= L1_ICACHE;
                req.wr    <= 1'b0;            // icache only reads
                req.addr  <= icache_addr;
                req.wdata <= '0;
            end
        end
    end

endmodule

//--- src/l2_tag_dirty_store.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_tag_dirty_store (
    input  logic                  clk,
    input  logic                  rstn,
    input  l2_pkg::l1_req_t       req,
    input  l2_pkg::fsm_ctrl_t     ctrl,
    output l2_pkg::way_vec_t      hit,
    output logic [`L2_WAY_W-1:0]  hit_way,
    output logic                  way_dirty,
    output logic [`L2_TAG_W-1:0]  way_tag
);

    localparam int IDX_LSB = `L2_BYTE_OFF_W + `L2_WORD_SEL_W;

    logic [`L2_SETS-1:0][`L2_WAYS-1:0] valid;
    logic [`L2_SETS-1:0][`L2_WAYS-1:0] dirty;
    logic [`L2_TAG_W-1:0]              tag_mem [`L2_SETS][`L2_WAYS];

    logic [`L2_INDEX_W-1:0] idx;
    logic [`L2_TAG_W-1:0]   req_tag;

    assign idx     = req.addr[IDX_LSB +: `L2_INDEX_W];
    assign req_tag = req.addr[`L2_ADDR_W-1 -: `L2_TAG_W];

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit[w] = valid[idx][w] && (tag_mem[idx][w] == req_tag);
        end
        // lowest hit wins
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (hit[w]) hit_way = w[`L2_WAY_W-1:0];
        end
    end

    assign way_dirty = dirty[idx][ctrl.way];   // way picked by the FSM
    assign way_tag   = tag_mem[idx][ctrl.way];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (ctrl.fill) valid[idx][ctrl.way] <= 1'b1;
            if (ctrl.set_dirty) dirty[idx][ctrl.way] <= 1'b1;
            else if (ctrl.clr_dirty) dirty[idx][ctrl.way] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.fill) tag_mem[idx][ctrl.way] <= req_tag;
    end

endmodule

//--- src/l2_victim_plru.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_victim_plru (
    input  logic                 clk,
    input  logic                 rstn,
    input  l2_pkg::l1_req_t      req,
    input  l2_pkg::fsm_ctrl_t    ctrl,
    output logic [`L2_WAY_W-1:0] victim
);

    localparam int IDX_LSB = `L2_BYTE_OFF_W + `L2_WORD_SEL_W;

    // node 0 root, 1..2 middle, 3..6 leaves; bit names the side to evict
    logic [`L2_SETS-1:0][`L2_PLRU_W-1:0] tree;
    logic [`L2_INDEX_W-1:0]              idx;
    logic [`L2_PLRU_W-1:0]               cur;
    logic [2:0]                          walk_leaf;
    logic [2:0]                          upd_mid;
    logic [2:0]                          upd_leaf;

    assign idx = req.addr[IDX_LSB +: `L2_INDEX_W];
    assign cur = tree[idx];

    always_comb begin
        victim[2] = cur[0];
        victim[1] = victim[2] ? cur[2] : cur[1];
        walk_leaf = 3'd3 + {1'b0, victim[2], victim[1]};
        victim[0] = cur[walk_leaf];
    end

    assign upd_mid  = 3'd1 + {2'b00, ctrl.way[2]};
    assign upd_leaf = 3'd3 + {1'b0, ctrl.way[2:1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tree <= '0;
        end else if (ctrl.use_way) begin
            tree[idx][0]        <= ~ctrl.way[2];   // point away from used way
            tree[idx][upd_mid]  <= ~ctrl.way[1];
            tree[idx][upd_leaf] <= ~ctrl.way[0];
        end
    end

endmodule

//--- src/l2_data_store.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_data_store (
    input  logic                                    clk,
    input  l2_pkg::l1_req_t                         req,
    input  l2_pkg::fsm_ctrl_t                       ctrl,
    input  logic [`L2_BLOCK_W-1:0]                  mem_rdata,
    output logic [`L2_WAYS-1:0][`L2_BLOCK_W-1:0]    way_blocks
);

    localparam int IDX_LSB = `L2_BYTE_OFF_W + `L2_WORD_SEL_W;

    logic [`L2_BLOCK_W-1:0]    blocks [`L2_SETS][`L2_WAYS];
    logic [`L2_INDEX_W-1:0]    idx;
    logic [`L2_WORD_SEL_W-1:0] word;

    assign idx  = req.addr[IDX_LSB +: `L2_INDEX_W];
    assign word = req.addr[`L2_BYTE_OFF_W +: `L2_WORD_SEL_W];

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) way_blocks[w] = blocks[idx][w];
    end

    always_ff @(posedge clk) begin
        if (ctrl.fill) begin
            blocks[idx][ctrl.way] <= mem_rdata;                          // refill
        end else if (ctrl.word_we) begin
            blocks[idx][ctrl.way][word * `L2_DATA_W +: `L2_DATA_W] <= req.wdata;
        end
    end

endmodule

//--- src/l2_main_fsm.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_main_fsm (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 accept,
    input  l2_pkg::l1_req_t      req,
    input  l2_pkg::way_vec_t     hit,
    input  logic [`L2_WAY_W-1:0] hit_way,
    input  logic                 way_dirty,
    input  logic [`L2_WAY_W-1:0] victim,
    input  l2_pkg::mem_resp_t    mem_resp,
    output logic                 idle,
    output l2_pkg::fsm_ctrl_t    ctrl,
    output logic                 icache_data_ok,
    output logic                 dcache_data_ok
);
    import l2_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_LOOKUP, S_CHECK_DIRTY, S_CHECK_DIRTY1, S_WRITEBACK,
        S_REFILL_REQ, S_REFILL_WAIT, S_MERGE_WAIT, S_WRITE_MERGE
    } state_t;

    state_t               state, next_state;
    logic [`L2_WAY_W-1:0] sel;     // victim kept for the whole miss
    logic                 ret;     // block goes back to the client

    always_ff @(posedge clk) begin
        if (!rstn) state <= S_IDLE;
        else       state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (state == S_CHECK_DIRTY) sel <= victim;
    end

    assign idle = (state == S_IDLE);

    ////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        ctrl       = '0;
        ctrl.way   = sel;
        ret        = 1'b0;
        case (state)
            S_IDLE: if (accept) next_state = S_LOOKUP;
            S_LOOKUP: begin
                if (|hit) begin
                    ctrl.way     = hit_way;
                    ctrl.use_way = 1'b1;
                    if (req.wr) begin
                        ctrl.word_we   = 1'b1;  // write hit, no data_ok
                        ctrl.set_dirty = 1'b1;
                    end else begin
                        ret = 1'b1;
                    end
                    next_state = S_IDLE;
                end else begin
                    next_state = S_CHECK_DIRTY;
                end
            end
            S_CHECK_DIRTY: next_state = S_CHECK_DIRTY1;
            S_CHECK_DIRTY1: begin
                ctrl.capture_wb = way_dirty;
                next_state = way_dirty ? S_WRITEBACK : S_REFILL_REQ;
            end
            S_WRITEBACK: begin
                ctrl.req_w = 1'b1;
                if (mem_resp.addr_ok_w) next_state = S_REFILL_REQ;
            end
            S_REFILL_REQ: begin
                ctrl.req_r = 1'b1;
                if (mem_resp.addr_ok_r) next_state = S_REFILL_WAIT;
            end
            S_REFILL_WAIT: begin
                ctrl.rdy = 1'b1;
                if (mem_resp.data_ok) begin
                    ctrl.fill        = 1'b1;
                    ctrl.clr_dirty   = 1'b1;
                    ctrl.use_way     = 1'b1;
                    ctrl.return_fill = 1'b1;
                    ret              = ~req.wr;
                    next_state       = req.wr ? S_MERGE_WAIT : S_IDLE;
                end
            end
            S_MERGE_WAIT: next_state = S_WRITE_MERGE;
            S_WRITE_MERGE: begin
                ctrl.word_we   = 1'b1;   // word on top of refilled block
                ctrl.set_dirty = 1'b1;
                next_state     = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
        icache_data_ok = ret & (req.src == L1_ICACHE);
        dcache_data_ok = ret & (req.src == L1_DCACHE);
    end

endmodule

//--- src/l2_outbound.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_outbound (
    input  logic                                 clk,
    input  l2_pkg::l1_req_t                      req,
    input  l2_pkg::fsm_ctrl_t                    ctrl,
    input  logic [`L2_WAYS-1:0][`L2_BLOCK_W-1:0] way_blocks,
    input  logic [`L2_TAG_W-1:0]                 way_tag,
    input  logic [`L2_WAY_W-1:0]                 hit_way,
    input  l2_pkg::mem_resp_t                    mem_resp,
    output l2_pkg::mem_req_t                     mem_req,
    output logic [`L2_BLOCK_W-1:0]               rdata
);

    localparam int IDX_LSB = `L2_BYTE_OFF_W + `L2_WORD_SEL_W;

    logic [`L2_ADDR_W-1:0]  wb_addr;
    logic [`L2_BLOCK_W-1:0] wb_data;
    logic [`L2_ADDR_W-1:0]  blk_addr;

    assign blk_addr = {req.addr[`L2_ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};

    // victim snapshot, held through the write handshake
    always_ff @(posedge clk) begin
        if (ctrl.capture_wb) begin
            wb_addr <= {way_tag, req.addr[IDX_LSB +: `L2_INDEX_W], {IDX_LSB{1'b0}}};
            wb_data <= way_blocks[ctrl.way];
        end
    end

    always_comb begin
        mem_req.req_r = ctrl.req_r;
        mem_req.req_w = ctrl.req_w;
        mem_req.rdy   = ctrl.rdy;
        mem_req.addr  = ctrl.req_w ? wb_addr : blk_addr;
        mem_req.wdata = wb_data;
    end

    // one block bus for both clients
    assign rdata = ctrl.return_fill ? mem_resp.rdata : way_blocks[hit_way];

endmodule

//--- src/l2_cache_top.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_cache_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   icache_req,
    input  logic [`L2_ADDR_W-1:0]  icache_addr,
    output logic                   icache_addr_ok,
    output logic                   icache_data_ok,
    input  logic                   dcache_req,
    input  logic                   dcache_wr,
    input  logic [`L2_ADDR_W-1:0]  dcache_addr,
    input  logic [`L2_DATA_W-1:0]  dcache_wdata,
    output logic                   dcache_addr_ok,
    output logic                   dcache_data_ok,
    output logic [`L2_BLOCK_W-1:0] rdata,
    output l2_pkg::mem_req_t       mem_req,
    input  l2_pkg::mem_resp_t      mem_resp
);
    import l2_pkg::*;

    l1_req_t                             req;
    fsm_ctrl_t                           ctrl;
    way_vec_t                            hit;
    logic                                idle;
    logic                                accept;
    logic [`L2_WAY_W-1:0]                hit_way;
    logic [`L2_WAY_W-1:0]                victim;
    logic                                way_dirty;
    logic [`L2_TAG_W-1:0]                way_tag;
    logic [`L2_WAYS-1:0][`L2_BLOCK_W-1:0] way_blocks;

    ////////////////////////////////////////
    // input, storage, control, output
    ////////////////////////////////////////

    l2_req_buffer u_req_buffer (
        .clk, .rstn, .icache_req, .icache_addr, .dcache_req, .dcache_wr,
        .dcache_addr, .dcache_wdata, .idle, .icache_addr_ok, .dcache_addr_ok,
        .accept, .req
    );

    l2_tag_dirty_store u_tag_dirty (
        .clk, .rstn, .req, .ctrl, .hit, .hit_way, .way_dirty, .way_tag
    );

    l2_victim_plru u_plru (.clk, .rstn, .req, .ctrl, .victim);

    l2_data_store u_data (
        .clk, .req, .ctrl, .mem_rdata(mem_resp.rdata), .way_blocks
    );

    l2_main_fsm u_fsm (
        .clk, .rstn, .accept, .req, .hit, .hit_way, .way_dirty, .victim,
        .mem_resp, .idle, .ctrl, .icache_data_ok, .dcache_data_ok
    );

    l2_outbound u_outbound (
        .clk, .req, .ctrl, .way_blocks, .way_tag, .hit_way, .mem_resp,
        .mem_req, .rdata
    );

endmodule

//--- tests/l2_cache_assertions.sv
`timescale 1ns/1ps

module l2_cache_assertions (
    input logic              clk,
    input logic              rstn,
    input logic              icache_addr_ok,
    input logic              dcache_addr_ok,
    input logic              icache_data_ok,
    input logic              dcache_data_ok,
    input l2_pkg::mem_req_t  mem_req,
    input l2_pkg::mem_resp_t mem_resp
);

    // one winner per acceptance
    one_addr_ok: assert property (@(posedge clk) disable iff (!rstn)
        !(icache_addr_ok && dcache_addr_ok))
        else $error("icache and dcache addr_ok high in the same cycle");

    mem_one_dir: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req.req_r && mem_req.req_w))
        else $error("memory read and write requested together");

    req_r_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req.req_r && !mem_resp.addr_ok_r) |=> mem_req.req_r)
        else $error("req_r dropped before addr_ok_r");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> !(icache_addr_ok | dcache_addr_ok | icache_data_ok |
                          dcache_data_ok | mem_req.req_r | mem_req.req_w | mem_req.rdy))
        else $error("control outputs active right after reset");

endmodule

//--- tests/tb_l2_cache.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module tb_l2_cache;
    import l2_pkg::*;

    localparam int TIMEOUT    = 300;   // cycles per wait
    localparam int RANDOM_OPS = 200;

    logic                   clk          = 1'b0;
    logic                   rstn         = 1'b0;
    logic                   icache_req   = 1'b0;
    logic [`L2_ADDR_W-1:0]  icache_addr  = '0;
    logic                   dcache_req   = 1'b0;
    logic                   dcache_wr    = 1'b0;
    logic [`L2_ADDR_W-1:0]  dcache_addr  = '0;
    logic [`L2_DATA_W-1:0]  dcache_wdata = '0;
    mem_resp_t              mem_resp     = '0;
    mem_req_t               mem_req;
    logic                   icache_addr_ok;
    logic                   icache_data_ok;
    logic                   dcache_addr_ok;
    logic                   dcache_data_ok;
    logic [`L2_BLOCK_W-1:0] rdata;

    // shadow of memory with all accepted dcache writes, and the model's own store
    logic [`L2_BLOCK_W-1:0] shadow [logic [31:0]];
    logic [`L2_BLOCK_W-1:0] mem_store [logic [31:0]];

    int          mismatches = 0;
    int          errors     = 0;
    int          timeouts   = 0;
    int          wb_count   = 0;
    bit          abort      = 1'b0;
    logic [31:0] stim_rng   = 32'd79243;
    logic [31:0] mem_rng    = 32'd79243;

    logic                   busy = 1'b0;   // read in flight
    logic                   exp_dc;
    logic [`L2_BLOCK_W-1:0] exp_blk;
    logic [`L2_BLOCK_W-1:0] last_rdata;
    int                     lat;
    int                     last_latency;

    logic        read_pend = 1'b0;
    logic [31:0] read_addr;
    int          delay     = 0;

    l2_cache_top DUT (.*);

    bind l2_cache_top l2_cache_assertions u_assertions (
        .clk(clk), .rstn(rstn), .icache_addr_ok(icache_addr_ok),
        .dcache_addr_ok(dcache_addr_ok), .icache_data_ok(icache_data_ok),
        .dcache_data_ok(dcache_data_ok), .mem_req(mem_req), .mem_resp(mem_resp)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // unwritten memory, every word depends on its full address
    function automatic logic [`L2_BLOCK_W-1:0] init_block(input logic [31:0] blk);
        logic [`L2_BLOCK_W-1:0] b;
        logic [31:0]            a;
        for (int w = 0; w < `L2_WORDS; w++) begin
            a = blk + 32'(w * 4);
            b[w*32 +: 32] = (a * 32'h9e3779b1) ^ 32'h5bd1e995;
        end
        return b;
    endfunction

    function automatic logic [`L2_BLOCK_W-1:0] expect_block(input logic [31:0] addr);
        logic [31:0] blk;
        blk = {addr[31:4], 4'b0000};
        if (shadow.exists(blk)) return shadow[blk];
        return init_block(blk);
    endfunction

    function automatic logic [`L2_BLOCK_W-1:0] fetch_block(input logic [31:0] blk);
        if (mem_store.exists(blk)) return mem_store[blk];
        return init_block(blk);
    endfunction

    task automatic apply_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [`L2_BLOCK_W-1:0] b;
        logic [31:0]            blk;
        blk = {addr[31:4], 4'b0000};
        b = expect_block(blk);
        b[int'(addr[3:2]) * 32 +: 32] = wdata;
        shadow[blk] = b;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic log_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic flag_timeout(input string what, input logic dc);
        $display("timeout at %0t: no %s for %s within %0d cycles", $time, what,
                 dc ? "dcache" : "icache", TIMEOUT);
        timeouts++;
        abort = 1'b1;   // later waits fall through
    endtask

    ////////////////////////////////////////
    // memory model, answers 1 ns after the edge
    ////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        mem_resp.addr_ok_r = 1'b0;
        mem_resp.addr_ok_w = 1'b0;
        mem_resp.data_ok   = 1'b0;
        if (!rstn) begin
            read_pend = 1'b0;
            delay     = 0;
        end else if (delay != 0) begin
            delay--;
        end else if (read_pend && mem_req.rdy) begin
            mem_resp.data_ok = 1'b1;
            mem_resp.rdata   = fetch_block(read_addr);
            read_pend        = 1'b0;
            mem_rng = lcg_next(mem_rng);
            delay   = int'(mem_rng[29:28]);
        end else if (!read_pend && mem_req.req_w) begin
            mem_resp.addr_ok_w = 1'b1;       // write lands this cycle
            assert (mem_req.addr[3:0] == 4'd0)
                else log_error("writeback address not block aligned");
            assert (mem_req.wdata == expect_block(mem_req.addr))
                else report_mismatch("mem_req.wdata", mem_req.wdata, expect_block(mem_req.addr));
            mem_store[mem_req.addr] = mem_req.wdata;
            wb_count++;
            mem_rng = lcg_next(mem_rng);
            delay   = int'(mem_rng[29:28]);
        end else if (!read_pend && mem_req.req_r) begin
            mem_resp.addr_ok_r = 1'b1;
            read_addr = mem_req.addr;
            read_pend = 1'b1;
            mem_rng = lcg_next(mem_rng);
            delay   = int'(mem_rng[29:28]);
        end
    end

    ////////////////////////////////////////
    // compare, sampled at the falling edge
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstn) begin
            busy = 1'b0;
        end else begin
            if (busy) lat++;
            if (icache_data_ok || dcache_data_ok) begin
                assert (busy) else log_error("data_ok with no read in flight");
                if (busy) begin
                    assert (dcache_data_ok == exp_dc && icache_data_ok != exp_dc)
                        else log_error("data_ok went to the wrong client");
                    assert (rdata == exp_blk) else report_mismatch("rdata", rdata, exp_blk);
                    last_rdata   = rdata;
                    last_latency = lat;
                    busy         = 1'b0;
                end
            end
            if (icache_addr_ok || dcache_addr_ok) begin
                assert (!busy) else log_error("request accepted while a read was in flight");
                if (dcache_addr_ok && dcache_wr) begin
                    apply_write(dcache_addr, dcache_wdata);
                end else begin
                    busy    = 1'b1;
                    lat     = 0;
                    exp_dc  = dcache_addr_ok;
                    exp_blk = expect_block(dcache_addr_ok ? dcache_addr : icache_addr);
                end
            end
        end
    end

    ////////////////////////////////////////
    // L1 side
    ////////////////////////////////////////

    task automatic wait_addr_ok(input logic dc);
        int n;
        n = 0;
        while (!abort) begin
            @(negedge clk);
            if (dc ? dcache_addr_ok : icache_addr_ok) break;
            n++;
            if (n == TIMEOUT) flag_timeout("addr_ok", dc);
        end
    endtask

    task automatic wait_data_ok(input logic dc);
        int n;
        n = 0;
        while (!abort) begin
            @(negedge clk);
            if (dc ? dcache_data_ok : icache_data_ok) break;
            n++;
            if (n == TIMEOUT) flag_timeout("data_ok", dc);
        end
    endtask

    task automatic access(input logic dc, input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata);
        @(posedge clk);
        #1;
        if (dc) begin
            dcache_req   = 1'b1;
            dcache_wr    = wr;
            dcache_addr  = addr;
            dcache_wdata = wdata;
        end else begin
            icache_req  = 1'b1;
            icache_addr = addr;
        end
        wait_addr_ok(dc);
        @(posedge clk);
        #1;
        icache_req = 1'b0;
        dcache_req = 1'b0;
        dcache_wr  = 1'b0;
        if (!wr) wait_data_ok(dc);   // writes end silently
    endtask

    // both clients in one cycle, dcache first
    task automatic check_arbitration(input logic [31:0] i_addr, input logic [31:0] d_addr);
        int   n;
        logic dseen;
        @(posedge clk);
        #1;
        icache_req  = 1'b1;
        icache_addr = i_addr;
        dcache_req  = 1'b1;
        dcache_wr   = 1'b0;
        dcache_addr = d_addr;
        n = 0;
        while (!abort) begin
            @(negedge clk);
            if (icache_addr_ok || dcache_addr_ok) break;
            n++;
            if (n == TIMEOUT) flag_timeout("addr_ok", 1'b1);
        end
        assert (abort || (dcache_addr_ok && !icache_addr_ok))
            else log_error("dcache did not win the tie");
        @(posedge clk);
        #1;
        dcache_req = 1'b0;
        dseen = 1'b0;
        n = 0;
        while (!abort) begin
            @(negedge clk);
            if (dcache_data_ok) dseen = 1'b1;
            if (icache_addr_ok) break;
            n++;
            if (n == TIMEOUT) flag_timeout("addr_ok", 1'b0);
        end
        assert (abort || dseen) else log_error("icache accepted before the dcache read ended");
        @(posedge clk);
        #1;
        icache_req = 1'b0;
        wait_data_ok(1'b0);
    endtask

    initial begin
        logic [31:0]            a;
        logic [31:0]            r;
        logic [`L2_BLOCK_W-1:0] first;

        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        repeat (3) begin
            @(negedge clk);
            assert (!(icache_addr_ok | dcache_addr_ok | icache_data_ok | dcache_data_ok |
                      mem_req.req_r | mem_req.req_w | mem_req.rdy))
                else log_error("outputs not low after reset");
        end

        // miss then hit on the same block
        access(1'b0, 1'b0, 32'h0012_3450, 32'd0);
        @(posedge clk);
        first = last_rdata;
        access(1'b1, 1'b0, 32'h0012_3458, 32'd0);
        @(posedge clk);
        assert (last_latency == 1)
            else report_mismatch("data_ok latency", 128'(last_latency), 128'd1);
        assert (last_rdata == first) else report_mismatch("rdata", last_rdata, first);

        // write hit, write miss
        access(1'b1, 1'b1, 32'h0012_3454, 32'hcafe_0001);
        access(1'b0, 1'b0, 32'h0012_3450, 32'd0);
        access(1'b1, 1'b1, 32'h0077_005c, 32'hbeef_0002);
        access(1'b1, 1'b0, 32'h0077_0050, 32'd0);

        // ten tags into set 9, two dirty evictions
        for (int t = 0; t < 10; t++) begin
            a = {24'h00b000 + 24'(t), 4'h9, 2'(t), 2'b00};
            access(1'b1, 1'b1, a, 32'hd000_0000 + 32'(t));
        end
        for (int t = 0; t < 10; t++) begin
            a = {24'h00b000 + 24'(t), 4'h9, 4'h0};
            access(1'b0, 1'b0, a, 32'd0);
        end
        @(posedge clk);
        assert (abort || wb_count > 0) else log_error("no writeback after set overflow");

        check_arbitration(32'h0033_0020, 32'h0044_0030);

        // few tags over four sets
        for (int i = 0; i < RANDOM_OPS && !abort; i++) begin
            stim_rng = lcg_next(stim_rng);
            r = stim_rng;
            stim_rng = lcg_next(stim_rng);
            a = {24'h00a000 + {20'd0, 4'(r[27:24] % 4'd11)}, r[21:20], 2'b11, r[19:18], 2'b00};
            case (r[31:30])
                2'd0:    access(1'b0, 1'b0, a, 32'd0);
                2'd1:    access(1'b1, 1'b0, a, 32'd0);
                default: access(1'b1, 1'b1, a, stim_rng);
            endcase
        end

        repeat (4) @(posedge clk);
        $display("mismatches %0d, errors %0d, timeouts %0d, writebacks %0d",
                 mismatches, errors, timeouts, wb_count);
        if (mismatches + errors + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/l2_pkg.sv
src/l2_req_buffer.sv
src/l2_tag_dirty_store.sv
src/l2_victim_plru.sv
src/l2_data_store.sv
src/l2_main_fsm.sv
src/l2_outbound.sv
src/l2_cache_top.sv
tests/l2_cache_assertions.sv
tests/tb_l2_cache.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_l2_cache
FILELIST   ?= all.f
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
